// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bram.sv ====
`timescale 1ns/1ps
`default_nettype none

module bram
  import cache_pkg::*;
#(
  parameter int address_bits = 6
) (
  input logic clk,
  input byte_en_t write_enable,
  input logic [address_bits-1:0] address,
  input word_t data_in,
  output word_t data_out
);

  localparam int depth = 2 ** address_bits;

  word_t mem [depth];

  // contents start cleared, so every tag word powers up invalid
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem[i] = '0;
    end
  end

  // read returns the old word when the same address is written
  always_ff @(posedge clk) begin
    data_out <= mem[address];
    for (int b = 0; b < 4; b++) begin
      if (write_enable[b]) begin
        mem[address][8*b +: 8] <= data_in[8*b +: 8];
      end
    end
  end

  a_wr_addr_known: assert property (@(posedge clk)
    (write_enable != '0) |-> !$isunknown(address));

endmodule

`default_nettype wire

// ==== burst_ram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_ram_model
  import cache_pkg::*;
#(
  parameter int read_latency = 6,
  parameter int command_delay_cycles = 13,
  parameter int ram_addressing_mode = 0,
  parameter int mem_words = 1 << 19,
  parameter word_t init_xor = 32'h5a3c_0000
) (
  input logic clk,
  input logic rst_n,
  input br_cmd_t br_cmd,
  output br_rsp_t br_rsp
);

  word_t mem [mem_words];

  // command log, read by the testbench
  int rd_count = 0;
  int wr_count = 0;
  int rd_cycle = 0;
  int wr_cycle = 0;
  int protocol_errors = 0;
  ram_addr_t rd_addr;
  ram_addr_t wr_addr;
  beat_t wr_beats [4];

  int cycle = 0;
  int last_cmd = -1000;
  int wr_word = 0;
  int wr_beat = 4;
  int rd_word = 0;
  int rd_wait = 0;
  int rd_left = 0;

  function automatic int word_index(ram_addr_t a);
    return ((int'(a) << ram_addressing_mode) >> 2) % mem_words;
  endfunction

  initial begin
    for (int i = 0; i < mem_words; i++) begin
      mem[i] = word_t'(i) ^ init_xor;
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      br_rsp <= '0;
      wr_beat = 4;
      rd_left = 0;
    end else begin
      cycle++;
      br_rsp.rd_data_valid <= 1'b0;
      // read beats go out back to back once the latency has passed
      if (rd_left > 0) begin
        if (rd_wait > 1) begin
          rd_wait--;
        end else begin
          br_rsp.rd_data <= {mem[rd_word + 1], mem[rd_word]};
          br_rsp.rd_data_valid <= 1'b1;
          rd_word += 2;
          rd_left--;
        end
      end
      if (br_cmd.cmd_en) begin
        if (cycle - last_cmd < command_delay_cycles + 1) begin
          $display("%0t: burst RAM commands only %0d cycles apart", $time, cycle - last_cmd);
          protocol_errors++;
        end
        last_cmd = cycle;
        if (br_cmd.cmd) begin
          wr_count++;
          wr_cycle = cycle;
          wr_addr = br_cmd.addr;
          wr_word = word_index(br_cmd.addr);
          wr_beat = 0;
        end else begin
          rd_count++;
          rd_cycle = cycle;
          rd_addr = br_cmd.addr;
          rd_word = word_index(br_cmd.addr);
          rd_wait = read_latency;
          rd_left = 4;
        end
      end
      // beat 0 comes with the command, beats 1 to 3 in the next cycles
      if (wr_beat < 4) begin
        wr_beats[wr_beat] = br_cmd.wr_data;
        mem[wr_word + 2 * wr_beat] = br_cmd.wr_data[31:0];
        mem[wr_word + 2 * wr_beat + 1] = br_cmd.wr_data[63:32];
        wr_beat++;
      end
    end
  end

endmodule

`default_nettype wire

// ==== cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache
  import cache_pkg::*;
#(
  parameter int line_index_bits = 6,
  parameter int command_delay_cycles = 13,
  parameter int ram_addressing_mode = 0
) (
  input logic clk,
  input logic rst_n,
  input logic enable,
  input cpu_req_t req,
  output cpu_rsp_t rsp,
  output br_cmd_t br_cmd,
  input br_rsp_t br_rsp
);

  localparam int col_bits = 3;
  localparam int col_count = 2 ** col_bits;
  // two low address bits select the byte inside a word
  localparam int offset_bits = col_bits + 2;
  localparam int tag_w = ram_addr_w + ram_addressing_mode - line_index_bits - offset_bits;
  localparam int line_shift = offset_bits - ram_addressing_mode;
  localparam int cnt_w = $clog2(command_delay_cycles + 1);

  // address split: | tag | line | col | 00 |
  logic [col_bits-1:0] column_ix;
  logic [line_index_bits-1:0] line_ix;
  logic [tag_w-1:0] addr_tag;

  assign column_ix = req.address[2 +: col_bits];
  assign line_ix = req.address[offset_bits +: line_index_bits];
  assign addr_tag = req.address[offset_bits + line_index_bits +: tag_w];

  // tag word layout is {dirty, valid, tag}
  word_t tag_rd;
  word_t tag_wd;
  logic tag_we;
  logic [tag_w-1:0] cached_tag;
  logic line_valid;
  logic line_dirty;

  assign cached_tag = tag_rd[tag_w-1:0];
  assign line_valid = tag_rd[tag_w];
  assign line_dirty = tag_rd[tag_w+1];

  word_t col_rd [col_count];
  word_t col_wd [col_count];
  byte_en_t col_we [col_count];

  bram #(
    .address_bits(line_index_bits)
  ) tag_mem (
    .clk,
    .write_enable({4{tag_we}}),
    .address(line_ix),
    .data_in(tag_wd),
    .data_out(tag_rd)
  );

  for (genvar i = 0; i < col_count; i++) begin : g_col
    bram #(
      .address_bits(line_index_bits)
    ) col_mem (
      .clk,
      .write_enable(col_we[i]),
      .address(line_ix),
      .data_in(col_wd[i]),
      .data_out(col_rd[i])
    );
  end

  cache_state_e state;
  logic [cnt_w-1:0] cmd_cnt;
  beat_t fill_beat;
  logic [1:0] fill_pair;
  logic fill_we;

  // line index behind the registered memory outputs
  logic [line_index_bits-1:0] rd_line;
  // a tag write on the last edge leaves the outputs one cycle behind
  logic tag_wr_q;
  logic lookup_fresh;
  logic line_hit;
  logic line_miss;
  logic write_hit;

  assign lookup_fresh = (rd_line == line_ix) && !tag_wr_q;
  assign line_hit = lookup_fresh && line_valid && (cached_tag == addr_tag);
  assign line_miss = lookup_fresh && !(line_valid && (cached_tag == addr_tag));
  assign write_hit = (state == idle) && enable && (req.write_enable != '0) && line_hit
                     && (cmd_cnt == '0);

  ram_addr_t req_line_addr;
  ram_addr_t old_line_addr;

  assign req_line_addr = {addr_tag, line_ix, {line_shift{1'b0}}};
  assign old_line_addr = {cached_tag, line_ix, {line_shift{1'b0}}};

  assign rsp.data_out = col_rd[column_ix];
  assign rsp.data_out_ready = enable && (req.write_enable == '0) && line_hit;
  assign rsp.busy = (enable && !line_hit) || (cmd_cnt != '0);

  // column and tag write steering
  always_comb begin
    for (int i = 0; i < col_count; i++) begin
      col_we[i] = '0;
      col_wd[i] = req.data_in;
    end
    tag_we = 1'b0;
    tag_wd = word_t'({2'b11, addr_tag});
    fill_pair = 2'd0;
    fill_we = 1'b1;

    // each fill state writes the beat captured on the previous edge
    case (state)
      read1: fill_pair = 2'd0;
      read2: fill_pair = 2'd1;
      read3: fill_pair = 2'd2;
      read_finish: begin
        fill_pair = 2'd3;
        tag_we = 1'b1;
        tag_wd = word_t'({2'b01, addr_tag});
      end
      default: fill_we = 1'b0;
    endcase

    if (fill_we) begin
      col_we[{fill_pair, 1'b0}] = '1;
      col_wd[{fill_pair, 1'b0}] = fill_beat[31:0];
      col_we[{fill_pair, 1'b1}] = '1;
      col_wd[{fill_pair, 1'b1}] = fill_beat[63:32];
    end else if (write_hit) begin
      // merge the written bytes and mark the line dirty
      col_we[column_ix] = req.write_enable;
      tag_we = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    rd_line <= line_ix;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= idle;
      cmd_cnt <= '0;
      tag_wr_q <= 1'b0;
      br_cmd.cmd_en <= 1'b0;
    end else begin
      tag_wr_q <= tag_we;
      br_cmd.cmd_en <= 1'b0;
      if (cmd_cnt != '0) begin
        cmd_cnt <= cmd_cnt - 1'b1;
      end

      case (state)
        idle: begin
          if (enable && line_miss && cmd_cnt == '0) begin
            br_cmd.cmd_en <= 1'b1;
            cmd_cnt <= cnt_w'(command_delay_cycles);
            if (line_dirty) begin
              // evict the old line first, beat 0 goes out with the command
              br_cmd.cmd <= 1'b1;
              br_cmd.addr <= old_line_addr;
              br_cmd.wr_data <= {col_rd[1], col_rd[0]};
              state <= write1;
            end else begin
              br_cmd.cmd <= 1'b0;
              br_cmd.addr <= req_line_addr;
              state <= read_wait;
            end
          end
        end

        read_wait: begin
          if (br_rsp.rd_data_valid) begin
            fill_beat <= br_rsp.rd_data;
            state <= read1;
          end
        end

        // remaining beats follow back to back, no back-pressure
        read1: begin
          fill_beat <= br_rsp.rd_data;
          state <= read2;
        end

        read2: begin
          fill_beat <= br_rsp.rd_data;
          state <= read3;
        end

        read3: begin
          fill_beat <= br_rsp.rd_data;
          state <= read_finish;
        end

        read_finish: begin
          state <= idle;
        end

        write1: begin
          br_cmd.wr_data <= {col_rd[3], col_rd[2]};
          state <= write2;
        end

        write2: begin
          br_cmd.wr_data <= {col_rd[5], col_rd[4]};
          state <= write3;
        end

        write3: begin
          br_cmd.wr_data <= {col_rd[7], col_rd[6]};
          state <= write_finish;
        end

        write_finish: begin
          // fetch the new line once the command interval has passed
          if (cmd_cnt == '0) begin
            br_cmd.cmd_en <= 1'b1;
            br_cmd.cmd <= 1'b0;
            br_cmd.addr <= req_line_addr;
            cmd_cnt <= cnt_w'(command_delay_cycles);
            state <= read_wait;
          end
        end

        default: state <= idle;
      endcase
    end
  end

  a_cmd_en_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd.cmd_en |=> !br_cmd.cmd_en);

  a_no_beat_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    (state == idle) |-> !br_rsp.rd_data_valid);

  // controller needs command_delay_cycles + 1 cycles between commands
  a_cmd_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd.cmd_en |=> !br_cmd.cmd_en [*command_delay_cycles]);

endmodule

`default_nettype wire

// ==== cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // burst RAM address width of the PSRAM controller
  localparam int ram_addr_w = 21;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  // one bit per byte lane, all zeros is a read
  typedef logic [3:0] byte_en_t;
  // two words per beat, low word first
  typedef logic [63:0] beat_t;
  typedef logic [ram_addr_w-1:0] ram_addr_t;

  // processor request, held stable while busy
  typedef struct packed {
    addr_t address;
    word_t data_in;
    byte_en_t write_enable;
  } cpu_req_t;

  typedef struct packed {
    word_t data_out;
    logic data_out_ready;
    logic busy;
  } cpu_rsp_t;

  // cmd is 1 for a write burst, 0 for a read burst
  typedef struct packed {
    logic cmd;
    logic cmd_en;
    ram_addr_t addr;
    beat_t wr_data;
  } br_cmd_t;

  typedef struct packed {
    beat_t rd_data;
    logic rd_data_valid;
  } br_rsp_t;

  typedef enum logic [3:0] {
    idle,
    read_wait,
    read1,
    read2,
    read3,
    read_finish,
    write1,
    write2,
    write3,
    write_finish
  } cache_state_e;

endpackage

`default_nettype wire

// ==== cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb
  import cache_pkg::*;
();

  localparam int command_delay_cycles = 13;
  localparam int ram_addressing_mode = 0;
  localparam int timeout_cycles = 200;
  localparam word_t init_xor = 32'h5a3c_0000;

  logic clk;
  logic rst_n;
  logic enable;
  cpu_req_t req;
  cpu_rsp_t rsp;
  br_cmd_t br_cmd;
  br_rsp_t br_rsp;

  // written words keyed by byte address / 4 override the RAM fill pattern
  word_t ref_mem [int];
  int seed = 60;
  int test_errors = 0;
  int pass_count = 0;
  int fail_count = 0;
  int proto_seen = 0;
  int rd0 = 0;
  int wr0 = 0;
  addr_t base;

  tb_clock #(.period_ns(100), .reset_cycles(3)) clock_i (.clk, .rst_n);

  cache_top #(
    .line_index_bits(6),
    .command_delay_cycles(command_delay_cycles),
    .ram_addressing_mode(ram_addressing_mode)
  ) cache_top_i (.clk, .rst_n, .enable, .req, .rsp, .br_cmd, .br_rsp);

  burst_ram_model #(
    .read_latency(6),
    .command_delay_cycles(command_delay_cycles),
    .ram_addressing_mode(ram_addressing_mode),
    .init_xor(init_xor)
  ) ram_model_i (.clk, .rst_n, .br_cmd, .br_rsp);

  function automatic word_t ref_word(addr_t a);
    int idx;
    idx = int'(a >> 2);
    if (ref_mem.exists(idx)) begin
      return ref_mem[idx];
    end
    return word_t'(idx) ^ init_xor;
  endfunction

  // tag and line index moved up to the RAM address unit
  function automatic ram_addr_t line_addr(addr_t a);
    return ram_addr_t'((a >> 5) << (5 - ram_addressing_mode));
  endfunction

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, actual);
    test_errors++;
  endtask

  task automatic start_test();
    test_errors = 0;
    rd0 = ram_model_i.rd_count;
    wr0 = ram_model_i.wr_count;
  endtask

  task automatic check_cmd_counts(input int rd_exp, input int wr_exp);
    if (ram_model_i.rd_count - rd0 != rd_exp) begin
      report_mismatch("read commands", rd_exp, ram_model_i.rd_count - rd0);
    end
    if (ram_model_i.wr_count - wr0 != wr_exp) begin
      report_mismatch("write commands", wr_exp, ram_model_i.wr_count - wr0);
    end
  endtask

  task automatic finish_test(input string name);
    if (ram_model_i.protocol_errors != proto_seen) begin
      $display("%s: burst RAM model saw commands too close together", name);
      test_errors++;
      proto_seen = ram_model_i.protocol_errors;
    end
    if (test_errors == 0) begin
      pass_count++;
      $display("%s: pass", name);
    end else begin
      fail_count++;
      $display("%s: fail with %0d errors", name, test_errors);
    end
  endtask

  // waited counts the cycles before data_out_ready
  task automatic read_check(input addr_t a, output int waited);
    bit done;
    done = 1'b0;
    waited = 0;
    @(posedge clk);
    enable <= 1'b1;
    req.address <= a;
    req.write_enable <= '0;
    while (!done && waited < timeout_cycles) begin
      @(negedge clk);
      if (rsp.data_out_ready) begin
        done = 1'b1;
        if (rsp.data_out !== ref_word(a)) begin
          report_mismatch("data_out", ref_word(a), rsp.data_out);
        end
      end else begin
        waited++;
      end
    end
    if (!done) begin
      $display("read of address %h never saw data_out_ready", a);
      test_errors++;
    end
    @(posedge clk);
    enable <= 1'b0;
  endtask

  task automatic write_word(input addr_t a, input word_t d, input byte_en_t m);
    bit done;
    int waited;
    word_t w;
    done = 1'b0;
    waited = 0;
    @(posedge clk);
    enable <= 1'b1;
    req.address <= a;
    req.data_in <= d;
    req.write_enable <= m;
    while (!done && waited < timeout_cycles) begin
      @(negedge clk);
      if (rsp.data_out_ready) begin
        $display("data_out_ready went high during a write to %h", a);
        test_errors++;
      end
      if (!rsp.busy) begin
        done = 1'b1;
      end else begin
        waited++;
      end
    end
    if (!done) begin
      $display("write to address %h stayed busy", a);
      test_errors++;
    end
    // the bytes land on this edge
    @(posedge clk);
    enable <= 1'b0;
    req.write_enable <= '0;
    w = ref_word(a);
    for (int b = 0; b < 4; b++) begin
      if (m[b]) begin
        w[8*b +: 8] = d[8*b +: 8];
      end
    end
    ref_mem[int'(a >> 2)] = w;
  endtask

  task automatic read_miss_fill();
    int waited;
    start_test();
    for (int k = 0; k < 8; k++) begin
      read_check(base + 4 * k, waited);
    end
    check_cmd_counts(1, 0);
    if (ram_model_i.rd_addr !== line_addr(base)) begin
      report_mismatch("br_cmd.addr", line_addr(base), ram_model_i.rd_addr);
    end
    finish_test("read miss fill");
  endtask

  task automatic read_hit_latency();
    int waited;
    start_test();
    for (int k = 0; k < 8; k++) begin
      // park on another line so the lookup has to be redone
      @(posedge clk);
      req.address <= base ^ 32'h20;
      read_check(base + 4 * k, waited);
      if (waited != 1) begin
        report_mismatch("data_out_ready delay", 1, waited);
      end
    end
    check_cmd_counts(0, 0);
    finish_test("read hit");
  endtask

  task automatic masked_write_hit();
    int waited;
    byte_en_t m;
    start_test();
    for (int n = 0; n < 8; n++) begin
      m = byte_en_t'($random(seed));
      if (m == '0) begin
        m = 4'h1;
      end
      write_word(base + 4 * ($random(seed) & 7), $random(seed), m);
    end
    for (int k = 0; k < 8; k++) begin
      read_check(base + 4 * k, waited);
    end
    check_cmd_counts(0, 0);
    finish_test("byte-masked write hit");
  endtask

  task automatic dirty_eviction();
    int waited;
    addr_t evict;
    beat_t exp_beat;
    start_test();
    evict = base ^ 32'h800;
    read_check(evict, waited);
    check_cmd_counts(1, 1);
    if (ram_model_i.wr_addr !== line_addr(base)) begin
      report_mismatch("write br_cmd.addr", line_addr(base), ram_model_i.wr_addr);
    end
    for (int k = 0; k < 4; k++) begin
      exp_beat = {ref_word(base + 8 * k + 4), ref_word(base + 8 * k)};
      if (ram_model_i.wr_beats[k] !== exp_beat) begin
        report_mismatch("br_cmd.wr_data", exp_beat, ram_model_i.wr_beats[k]);
      end
    end
    if (ram_model_i.rd_addr !== line_addr(evict)) begin
      report_mismatch("read br_cmd.addr", line_addr(evict), ram_model_i.rd_addr);
    end
    if (ram_model_i.rd_cycle - ram_model_i.wr_cycle != command_delay_cycles + 1) begin
      report_mismatch("command spacing", command_delay_cycles + 1,
                      ram_model_i.rd_cycle - ram_model_i.wr_cycle);
    end
    for (int k = 1; k < 8; k++) begin
      read_check(evict + 4 * k, waited);
    end
    // the written-back line comes back from RAM
    for (int k = 0; k < 8; k++) begin
      read_check(base + 4 * k, waited);
    end
    check_cmd_counts(2, 1);
    finish_test("dirty eviction");
  endtask

  task automatic clean_miss();
    int waited;
    addr_t other;
    start_test();
    other = base ^ 32'h1000;
    for (int k = 0; k < 8; k += 3) begin
      read_check(other + 4 * k, waited);
    end
    check_cmd_counts(1, 0);
    if (ram_model_i.rd_addr !== line_addr(other)) begin
      report_mismatch("br_cmd.addr", line_addr(other), ram_model_i.rd_addr);
    end
    finish_test("clean miss");
  endtask

  task automatic disabled_idle();
    int waited;
    int bad;
    start_test();
    waited = 0;
    bad = 0;
    @(posedge clk);
    enable <= 1'b0;
    // the command interval may still hold busy
    @(negedge clk);
    while (rsp.busy && waited < timeout_cycles) begin
      @(negedge clk);
      waited++;
    end
    if (rsp.busy) begin
      $display("busy did not fall with enable low");
      test_errors++;
    end
    repeat (50) begin
      @(posedge clk);
      req.address <= addr_t'($random(seed)) & 32'h001f_fffc;
      @(negedge clk);
      if (rsp.busy || rsp.data_out_ready) begin
        bad++;
      end
    end
    if (bad != 0) begin
      $display("busy or data_out_ready high on %0d of 50 disabled cycles", bad);
      test_errors++;
    end
    check_cmd_counts(0, 0);
    finish_test("disabled");
  endtask

  initial begin
    int waited;
    enable = 1'b0;
    req = '0;
    base = addr_t'($random(seed)) & 32'h001f_ffe0;
    waited = 0;
    while (!rst_n && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      fail_count++;
    end
    read_miss_fill();
    read_hit_latency();
    masked_write_hit();
    dirty_eviction();
    clean_miss();
    disabled_idle();
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top
  import cache_pkg::*;
#(
  // cache holds 2^line_index_bits lines of eight words
  parameter int line_index_bits = 6,
  // idle cycles the PSRAM controller needs after a command
  parameter int command_delay_cycles = 13,
  // bytes per RAM address: 0 is 1, 1 is 2, 2 is 4, 3 is 8
  parameter int ram_addressing_mode = 0
) (
  input logic clk,
  input logic rst_n,
  input logic enable,
  input cpu_req_t req,
  output cpu_rsp_t rsp,
  output br_cmd_t br_cmd,
  input br_rsp_t br_rsp
);

  cache #(
    .line_index_bits(line_index_bits),
    .command_delay_cycles(command_delay_cycles),
    .ram_addressing_mode(ram_addressing_mode)
  ) cache_i (
    .clk,
    .rst_n,
    .enable,
    .req,
    .rsp,
    .br_cmd,
    .br_rsp
  );

endmodule

`default_nettype wire

// ==== src.f ====
cache_pkg.sv
bram.sv
cache.sv
cache_top.sv
tb_clock.sv
burst_ram_model.sv
cache_tb.sv

// ==== tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int period_ns = 100,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // reset released on a rising edge, after reset_cycles full cycles
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire
